// ==== verilog/mbxCtl_settings.svh ====
`ifndef MBXCTL_SETTINGS_SVH
`define MBXCTL_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Memory buffer geometry
////////////////////////////////////////////////////////////////////////////

// Words held in the memory buffer
`define MBX_WORDS 4

// Bits needed to name one buffer word
`define MBX_WORD_ADR_W 2

// Served-word count, wide enough to hold MBX_WORDS itself
`define MBX_COUNT_W 3

`endif

// ==== verilog/mbxPkg.sv ====
`include "mbxCtl_settings.svh"

package mbxPkg;

  // Bit i stands for buffer word i
  typedef logic [`MBX_WORDS-1:0] wordMask;

  typedef logic [`MBX_WORD_ADR_W-1:0] wordAdr;

  // Cycle types seen by the memory buffer
  typedef enum logic [2:0] {
    coreRead    = 3'd0,
    pageRefill  = 3'd1,
    chanRead    = 3'd2,
    oneWordRead = 3'd3,
    cacheWrite  = 3'd4,
    chanWrite   = 3'd5,
    writeback   = 3'd6
  } cycleType;

  // One cycle command from the cache side
  typedef struct packed {
    cycleType kind;
    wordAdr   adr;
    wordMask  valid;
    wordMask  needed;
  } mbxCmd;

  // Decoded word requests, handed to execute
  typedef struct packed {
    wordMask mask;
    logic    isWrite;
  } mbxRequest;

  // One word request toward memory
  typedef struct packed {
    wordAdr adr;
    logic   isWrite;
  } mbxIssue;

  typedef struct packed {
    logic                    isWrite;
    wordMask                 served;
    logic [`MBX_COUNT_W-1:0] count;
  } mbxDone;

endpackage

// ==== verilog/mbxDecode.sv ====
module mbxDecode (
  input  logic              clk,
  input  logic              reset,
  input  mbxPkg::mbxCmd     cmd,
  input  logic              cmdValid,
  input  logic              execIdle,
  output logic              cmdReady,
  output mbxPkg::mbxRequest request,
  output logic              reqValid
);

  import mbxPkg::*;

  mbxRequest decoded;
  logic      accept;
  logic      load;
  logic      reqValidNext;
  // Mirrors reqValid, but comes out of reset set
  logic      holdReq;

  ////////////////////////////////////////////////////////////////////////////
  // Word request decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decoded.isWrite = 1'b0;
    case (cmd.kind)
      coreRead, pageRefill, chanRead: begin
        // Fetch only what the cache does not already hold
        decoded.mask = cmd.needed & ~cmd.valid;
      end
      oneWordRead: begin
        decoded.mask = wordMask'(1) << cmd.adr;
      end
      cacheWrite, chanWrite, writeback: begin
        decoded.mask    = cmd.needed;
        decoded.isWrite = 1'b1;
      end
      default: begin
        decoded.mask = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command handshake and request hold
  ////////////////////////////////////////////////////////////////////////////

  assign cmdReady = !holdReq && execIdle;
  assign accept   = cmdValid && cmdReady;
  assign load     = reqValid && execIdle;

  always_comb begin
    reqValidNext = reqValid;
    if (accept) begin
      reqValidNext = 1'b1;
    end else if (load) begin
      reqValidNext = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reqValid <= 1'b0;
      holdReq  <= 1'b1;
    end else begin
      reqValid <= reqValidNext;
      holdReq  <= reqValidNext;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      request <= decoded;
    end
  end

  // A held request blocks any new command until execute has taken it
  assert property (@(posedge clk) disable iff (reset)
    reqValid |-> !accept);

endmodule

// ==== verilog/mbxExecute.sv ====
`include "mbxCtl_settings.svh"

module mbxExecute (
  input  logic              clk,
  input  logic              reset,
  input  mbxPkg::mbxRequest request,
  input  logic              reqValid,
  input  logic              memAck,
  output logic              execIdle,
  output logic              memReq,
  output mbxPkg::mbxIssue   memIssue,
  output logic              startWrite,
  output logic              startValid,
  output mbxPkg::wordMask   served,
  output logic              servedValid,
  output logic              lastServed
);

  import mbxPkg::*;

  // Outstanding word stays in pending until memory acknowledges it
  wordMask pending;
  wordMask afterAck;
  wordMask curBit;
  wordAdr  curAdr;
  wordAdr  nextAdr;
  logic    isWrite;
  logic    load;
  logic    ackSeen;

  // Lowest numbered word wins
  function automatic wordAdr lowestWord(input wordMask m);
    lowestWord = '0;
    for (int i = `MBX_WORDS - 1; i >= 0; i--) begin
      if (m[i]) begin
        lowestWord = wordAdr'(i);
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Next word selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    load     = reqValid && execIdle;
    ackSeen  = memReq && memAck;
    curBit   = wordMask'(1) << curAdr;
    afterAck = ackSeen ? (pending & ~curBit) : pending;
    nextAdr  = lowestWord(afterAck);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
      memReq  <= 1'b0;
    end else begin
      if (load) begin
        pending <= request.mask;
      end else begin
        pending <= afterAck;
      end
      // Drops only once the last word is acknowledged
      memReq <= |afterAck;
    end
  end

  // Address is frozen while a request waits on memory
  always_ff @(posedge clk) begin
    if (!memReq || ackSeen) begin
      curAdr <= nextAdr;
    end
    if (load) begin
      isWrite <= request.isWrite;
    end
  end

  assign execIdle         = (pending == '0) && !memReq;
  assign memIssue.adr     = curAdr;
  assign memIssue.isWrite = isWrite;

  // Status toward result
  assign startWrite  = request.isWrite;
  assign startValid  = load;
  assign served      = curBit;
  assign servedValid = ackSeen;
  assign lastServed  = (ackSeen && afterAck == '0) || (load && request.mask == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Memory handshake checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (reset)
    memAck |-> memReq);

  assert property (@(posedge clk) disable iff (reset)
    memReq && !memAck |=> memReq && $stable(memIssue));

  // New words appear in pending only through a load
  assert property (@(posedge clk) disable iff (reset)
    !load |=> (pending & ~$past(pending)) == '0);

endmodule

// ==== verilog/mbxResult.sv ====
`include "mbxCtl_settings.svh"

module mbxResult (
  input  logic            clk,
  input  logic            reset,
  input  logic            startWrite,
  input  logic            startValid,
  input  mbxPkg::wordMask served,
  input  logic            servedValid,
  input  logic            lastServed,
  output mbxPkg::mbxDone  done,
  output logic            doneValid
);

  import mbxPkg::*;

  wordMask                 servedAcc;
  logic [`MBX_COUNT_W-1:0] countAcc;
  logic                    writeAcc;
  wordMask                 mergedMask;
  logic [`MBX_COUNT_W-1:0] mergedCount;
  logic                    mergedWrite;

  ////////////////////////////////////////////////////////////////////////////
  // Running totals, including the word acknowledged this cycle
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mergedMask  = servedAcc | (servedValid ? served : '0);
    mergedCount = countAcc + {{(`MBX_COUNT_W-1){1'b0}}, servedValid};
    // An empty command starts and finishes in the same cycle
    mergedWrite = startValid ? startWrite : writeAcc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      servedAcc <= '0;
      countAcc  <= '0;
      doneValid <= 1'b0;
    end else begin
      doneValid <= lastServed;
      if (lastServed) begin
        servedAcc <= '0;
        countAcc  <= '0;
      end else begin
        servedAcc <= mergedMask;
        countAcc  <= mergedCount;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startValid) begin
      writeAcc <= startWrite;
    end
    if (lastServed) begin
      done.isWrite <= mergedWrite;
      done.served  <= mergedMask;
      done.count   <= mergedCount;
    end
  end

endmodule

// ==== verilog/mbxTop.sv ====
module mbxTop (
  input  logic            clk,
  input  logic            reset,
  input  mbxPkg::mbxCmd   cmd,
  input  logic            cmdValid,
  input  logic            memAck,
  output logic            cmdReady,
  output logic            memReq,
  output mbxPkg::mbxIssue memIssue,
  output mbxPkg::mbxDone  done,
  output logic            doneValid
);

  import mbxPkg::*;

  mbxRequest request;
  logic      reqValid;
  logic      execIdle;
  logic      startWrite;
  logic      startValid;
  wordMask   served;
  logic      servedValid;
  logic      lastServed;

  mbxDecode i_decode (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .execIdle (execIdle),
    .cmdReady (cmdReady),
    .request  (request),
    .reqValid (reqValid)
  );

  mbxExecute i_execute (
    .clk         (clk),
    .reset       (reset),
    .request     (request),
    .reqValid    (reqValid),
    .memAck      (memAck),
    .execIdle    (execIdle),
    .memReq      (memReq),
    .memIssue    (memIssue),
    .startWrite  (startWrite),
    .startValid  (startValid),
    .served      (served),
    .servedValid (servedValid),
    .lastServed  (lastServed)
  );

  mbxResult i_result (
    .clk         (clk),
    .reset       (reset),
    .startWrite  (startWrite),
    .startValid  (startValid),
    .served      (served),
    .servedValid (servedValid),
    .lastServed  (lastServed),
    .done        (done),
    .doneValid   (doneValid)
  );

endmodule

// ==== sim/mbxTb.sv ====
`include "mbxCtl_settings.svh"

module mbxTb;

  timeunit 1ns;
  timeprecision 1ps;

  import mbxPkg::*;

  logic    clk;
  logic    reset;
  mbxCmd   cmd;
  logic    cmdValid;
  logic    memAck;
  logic    cmdReady;
  logic    memReq;
  mbxIssue memIssue;
  mbxDone  done;
  logic    doneValid;

  integer  seed = 32'h7ec5_3514;
  string   testName;
  mbxIssue expIssueQ[$];
  mbxDone  expDoneQ[$];
  int      outstanding = 0;
  int      cycleNo = 0;
  int      acceptCycle = -100;
  int      valueErrors = 0;
  int      protocolErrors = 0;
  int      timeoutErrors = 0;
  bit      stopRun = 1'b0;

  mbxTop i_dut (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmdValid  (cmdValid),
    .memAck    (memAck),
    .cmdReady  (cmdReady),
    .memReq    (memReq),
    .memIssue  (memIssue),
    .done      (done),
    .doneValid (doneValid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected behavior
  ////////////////////////////////////////////////////////////////////////////

  function automatic mbxDone expectedDone(input mbxCmd c);
    mbxDone d;
    d.served  = '0;
    d.count   = '0;
    d.isWrite = (c.kind == cacheWrite) || (c.kind == chanWrite) || (c.kind == writeback);
    for (int i = 0; i < `MBX_WORDS; i++) begin
      if (c.kind == oneWordRead) begin
        d.served[i] = (i == c.adr);
      end else if (d.isWrite) begin
        d.served[i] = c.needed[i];
      end else begin
        // Words already valid in the cache are not fetched again
        d.served[i] = c.needed[i] && !c.valid[i];
      end
      if (d.served[i]) begin
        d.count = d.count + 1'b1;
      end
    end
    return d;
  endfunction

  task automatic checkIssue(input string name, input mbxIssue exp, input mbxIssue act);
    if (act !== exp) begin
      valueErrors++;
      $display("ERR %s issue expected adr=%0d wr=%0b actual adr=%0d wr=%0b",
               name, exp.adr, exp.isWrite, act.adr, act.isWrite);
    end
  endtask

  task automatic checkDone(input string name, input mbxDone exp, input mbxDone act);
    if (act !== exp) begin
      valueErrors++;
      $display("ERR %s done expected wr=%0b served=%b count=%0d actual wr=%0b served=%b count=%0d",
               name, exp.isWrite, exp.served, exp.count, act.isWrite, act.served, act.count);
    end
  endtask

  task automatic flagProtocol(input string what);
    protocolErrors++;
    $display("Problem in %s: %s", testName, what);
  endtask

  task automatic flagTimeout(input string what);
    timeoutErrors++;
    stopRun = 1'b1;
    $display("Timeout in %s: %s", testName, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and compare process
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int ackDelay;
    ackDelay = -1;
    memAck = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      memAck = 1'b0;
      if (!reset && memReq) begin
        if (ackDelay < 0) begin
          ackDelay = $unsigned($random(seed)) % 4;
        end
        if (ackDelay == 0) begin
          memAck   = 1'b1;
          ackDelay = -1;
        end else begin
          ackDelay--;
        end
      end
    end
  end

  // Samples 1 ns after the edge, inputs still hold their values at that edge
  initial begin
    logic    prevReq;
    logic    prevReady;
    mbxIssue prevIssue;
    mbxIssue expI;
    mbxDone  expD;
    prevReq   = 1'b0;
    prevReady = 1'b0;
    prevIssue = '0;
    forever begin
      @(posedge clk);
      #1;
      cycleNo++;
      if (!reset) begin
        if (cmdValid && prevReady) begin
          outstanding++;
          acceptCycle = cycleNo;
        end
        if (memAck && prevReq) begin
          if (expIssueQ.size() == 0) begin
            flagProtocol("memory acknowledged a word that no command asked for");
          end else begin
            expI = expIssueQ.pop_front();
            checkIssue(testName, expI, prevIssue);
          end
        end else if (prevReq && (!memReq || memIssue !== prevIssue)) begin
          flagProtocol("memory request changed before it was acknowledged");
        end
        if (memReq && !prevReq && cycleNo - acceptCycle != 2) begin
          flagProtocol("memReq did not rise two cycles after the command was taken");
        end
        if (doneValid) begin
          if (expDoneQ.size() == 0) begin
            flagProtocol("completion reported with no command in progress");
          end else begin
            expD = expDoneQ.pop_front();
            checkDone(testName, expD, done);
          end
          outstanding--;
        end
        if (cmdReady && outstanding != 0) begin
          flagProtocol("cmdReady is high while a command is still in progress");
        end
      end
      prevReq   = memReq;
      prevReady = cmdReady;
      prevIssue = memIssue;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic makeCmd(input cycleType k, output mbxCmd c);
    c.kind   = k;
    c.adr    = wordAdr'($random(seed));
    c.valid  = wordMask'($random(seed));
    c.needed = wordMask'($random(seed));
  endtask

  task automatic sendCmd(input mbxCmd c);
    mbxDone  d;
    mbxIssue iss;
    bit      taken;
    int      waited;
    if (stopRun) begin
      return;
    end
    d = expectedDone(c);
    expDoneQ.push_back(d);
    for (int i = 0; i < `MBX_WORDS; i++) begin
      if (d.served[i]) begin
        iss.adr     = wordAdr'(i);
        iss.isWrite = d.isWrite;
        expIssueQ.push_back(iss);
      end
    end
    cmd      = c;
    cmdValid = 1'b1;
    taken    = 1'b0;
    waited   = 0;
    while (!taken && waited < 60) begin
      taken = cmdReady;
      @(posedge clk);
      #2;
      waited++;
    end
    cmdValid = 1'b0;
    if (!taken) begin
      flagTimeout("command was not accepted within 60 cycles");
    end
  endtask

  task automatic drainCommands();
    int waited;
    waited = 0;
    while ((outstanding != 0 || expIssueQ.size() != 0 || expDoneQ.size() != 0)
           && waited < 100 && !stopRun) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (outstanding != 0 || expIssueQ.size() != 0 || expDoneQ.size() != 0) begin
      flagTimeout("commands did not complete within 100 cycles");
    end
  endtask

  initial begin
    mbxCmd c;
    int    waited;
    reset    = 1'b1;
    cmd      = '0;
    cmdValid = 1'b0;
    testName = "reset";
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    if (memReq !== 1'b0 || doneValid !== 1'b0) begin
      flagProtocol("memReq or doneValid is high right after reset");
    end
    waited = 0;
    while (cmdReady !== 1'b1 && waited < 2) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (cmdReady !== 1'b1) begin
      flagTimeout("cmdReady did not rise within two cycles of reset");
    end

    testName = "oneWordRead";
    for (int a = 0; a < `MBX_WORDS; a++) begin
      makeCmd(oneWordRead, c);
      c.adr = wordAdr'(a);
      sendCmd(c);
    end
    drainCommands();

    testName = "nonValidRead";
    for (int n = 0; n < 12; n++) begin
      makeCmd(cycleType'(n % 3), c);
      sendCmd(c);
    end
    drainCommands();

    testName = "bufferedWrite";
    for (int n = 0; n < 9; n++) begin
      makeCmd(cycleType'(4 + n % 3), c);
      sendCmd(c);
    end
    // Nothing to move in either case
    makeCmd(chanWrite, c);
    c.needed = '0;
    sendCmd(c);
    makeCmd(coreRead, c);
    c.needed = c.valid;
    sendCmd(c);
    drainCommands();

    testName = "mixedTraffic";
    for (int n = 0; n < 24; n++) begin
      makeCmd(cycleType'($unsigned($random(seed)) % 7), c);
      sendCmd(c);
      repeat ($unsigned($random(seed)) % 3) begin
        @(posedge clk);
        #2;
      end
    end
    drainCommands();

    $display("Error counts: %0d value, %0d protocol, %0d timeout",
             valueErrors, protocolErrors, timeoutErrors);
    if (valueErrors + protocolErrors + timeoutErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/mbxPkg.sv
verilog/mbxDecode.sv
verilog/mbxExecute.sv
verilog/mbxResult.sv
verilog/mbxTop.sv
sim/mbxTb.sv
